//--- Bender.yml
package:
  name: dl_fc_init

sources:
  - include_dirs:
      - logic
    files:
      - logic/dl_pkg.sv
      - logic/dllp_crc16.sv
      - logic/fc_init_seq.sv
      - logic/dllp_skid_buffer.sv
      - logic/dllp_fc_receiver.sv
      - logic/dl_fc_init_top.sv
  - target: test
    include_dirs:
      - logic
      - test
    files:
      - test/tb_dl_fc_init.sv

//--- logic/dl_fc_init_top.sv
// DLL flow control init top
`timescale 1ns/10ps
`include "dl_params.svh"

module dl_fc_init_top (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                start_i,
  output dl_pkg::dllp_word_t  tx_word_o,
  output logic                tx_valid_o,
  input  logic                tx_ready_i,
  input  dl_pkg::dllp_word_t  rx_word_i,
  input  logic                rx_valid_i,
  output logic                init_ack_o,
  output logic                link_fc_done_o,
  output dl_pkg::fc_partner_t partner_o,
  output logic                crc_err_o
);
  import dl_pkg::*;

  dllp_word_t  seq_word;
  logic        seq_valid;
  logic        seq_ready;
  logic [31:0] tx_body;
  logic [15:0] tx_crc_word;
  logic [31:0] rx_body;
  logic [15:0] rx_crc_word;
  logic        fc1_stored;
  logic        fc2_stored;

  fc_init_seq seq (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .start_i        (start_i),
    .fc1_stored_i   (fc1_stored),
    .fc2_stored_i   (fc2_stored),
    .ready_i        (seq_ready),
    .crc_word_i     (tx_crc_word),
    .body_o         (tx_body),
    .word_o         (seq_word),
    .valid_o        (seq_valid),
    .init_ack_o     (init_ack_o),
    .link_fc_done_o (link_fc_done_o)
  );

  dllp_crc16 tx_crc (
    .body_i     (tx_body),
    .crc_word_o (tx_crc_word)
  );

  dllp_skid_buffer skid (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s_word_i  (seq_word),
    .s_valid_i (seq_valid),
    .s_ready_o (seq_ready),
    .m_word_o  (tx_word_o),
    .m_valid_o (tx_valid_o),
    .m_ready_i (tx_ready_i)
  );

  dllp_fc_receiver rx (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rx_word_i    (rx_word_i),
    .rx_valid_i   (rx_valid_i),
    .crc_word_i   (rx_crc_word),
    .body_o       (rx_body),
    .fc1_stored_o (fc1_stored),
    .fc2_stored_o (fc2_stored),
    .partner_o    (partner_o),
    .crc_err_o    (crc_err_o)
  );

  dllp_crc16 rx_crc (
    .body_i     (rx_body),
    .crc_word_o (rx_crc_word)
  );

endmodule

//--- logic/dl_params.svh
// DLL flow control constants
`ifndef DL_PARAMS_SVH
`define DL_PARAMS_SVH

// idle cycles between consecutive DLLPs
`define DL_FC_WAIT_CYCLES 2

// cycles to wait for the partner flag before repeating a phase
`define DL_FC_CHECK_CYCLES 8

// max payload in bytes
`define DL_MAX_PAYLOAD 256

// data credits are 16 byte units
`define DL_PD_MIN_CREDITS (`DL_MAX_PAYLOAD / 16)

`define DL_HDR_MIN_CREDITS 1

`endif

//--- logic/dl_pkg.sv
// DLL flow control types
package dl_pkg;

  // DLLP type byte, VC0 only
  typedef enum logic [7:0] {
    INITFC1_P   = 8'h40,
    INITFC1_NP  = 8'h50,
    INITFC1_CPL = 8'h60,
    INITFC2_P   = 8'hC0,
    INITFC2_NP  = 8'hD0,
    INITFC2_CPL = 8'hE0
  } dllp_type_e;

  // one stream word, valid travels beside it
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  keep;
    logic        last;
    logic [2:0]  user;
  } dllp_word_t;

  typedef struct packed {
    logic [7:0]  hdr;
    logic [11:0] data;
  } fc_credit_t;

  typedef struct packed {
    fc_credit_t posted;
    fc_credit_t non_posted;
    fc_credit_t completion;
  } fc_partner_t;

  // sequencer states, X waits the gap then sends X, X_CRC sends its CRC
  typedef enum logic [4:0] {
    ST_IDLE,
    ST_FC1_P,
    ST_FC1_P_CRC,
    ST_FC1_NP,
    ST_FC1_NP_CRC,
    ST_FC1_CPL,
    ST_FC1_CPL_CRC,
    ST_FC1_CHECK,
    ST_FC2_P,
    ST_FC2_P_CRC,
    ST_FC2_NP,
    ST_FC2_NP_CRC,
    ST_FC2_CPL,
    ST_FC2_CPL_CRC,
    ST_FC2_CHECK,
    ST_DONE
  } fc_seq_state_e;

endpackage

//--- logic/dllp_crc16.sv
// DLLP CRC16
`timescale 1ns/10ps
`include "dl_params.svh"

module dllp_crc16 (
  input  logic [31:0] body_i,
  output logic [15:0] crc_word_o
);

  logic [15:0] crc_c;
  logic [15:0] crc_inv;

  // poly 100B, seeded all ones, msb of the body first
  always_comb begin
    crc_c = 16'hFFFF;
    for (int i = 31; i >= 0; i--) begin
      if (crc_c[15] ^ body_i[i]) begin
        crc_c = {crc_c[14:0], 1'b0} ^ 16'h100B;
      end else begin
        crc_c = {crc_c[14:0], 1'b0};
      end
    end
  end

  assign crc_inv = ~crc_c;

  // on-wire order, bits reversed inside each byte
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      crc_word_o[i]     = crc_inv[7-i];
      crc_word_o[i+8]   = crc_inv[15-i];
    end
  end

endmodule

//--- logic/dllp_fc_receiver.sv
// DLLP FC init receiver
`timescale 1ns/10ps
`include "dl_params.svh"

module dllp_fc_receiver (
  input  logic                clk_i,
  input  logic                rst_i,
  input  dl_pkg::dllp_word_t  rx_word_i,
  input  logic                rx_valid_i,
  input  logic [15:0]         crc_word_i,
  output logic [31:0]         body_o,
  output logic                fc1_stored_o,
  output logic                fc2_stored_o,
  output dl_pkg::fc_partner_t partner_o,
  output logic                crc_err_o
);
  import dl_pkg::*;

  logic [31:0] body_q;
  logic        body_pend_q;
  logic        chk_valid_q;
  logic        chk_ok_q;
  logic [2:0]  seen_q;
  logic [2:0]  seen_d;
  logic        fc1_q;
  logic        fc2_q;
  logic        crc_err_q;
  fc_partner_t partner_q;
  dllp_type_e  rx_type;
  fc_credit_t  rx_credit;

  assign rx_type        = dllp_type_e'(body_q[31:24]);
  assign rx_credit.hdr  = body_q[21:14];
  assign rx_credit.data = body_q[11:0];
  assign body_o         = body_q;

  always_ff @(posedge clk_i) begin
    if (rx_valid_i && !rx_word_i.last) begin
      body_q <= rx_word_i.data;
    end
    if (rx_valid_i && rx_word_i.last) begin
      chk_ok_q <= (rx_word_i.data[15:0] == crc_word_i);
    end
  end

  // crc word without a body before it is dropped
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      body_pend_q <= 1'b0;
      chk_valid_q <= 1'b0;
    end else begin
      chk_valid_q <= 1'b0;
      if (rx_valid_i) begin
        if (!rx_word_i.last) begin
          body_pend_q <= 1'b1;
        end else begin
          body_pend_q <= 1'b0;
          chk_valid_q <= body_pend_q;
        end
      end
    end
  end

  always_comb begin
    seen_d = seen_q;
    case (rx_type)
      INITFC1_P:   seen_d[0] = 1'b1;
      INITFC1_NP:  seen_d[1] = 1'b1;
      INITFC1_CPL: seen_d[2] = 1'b1;
      default:     seen_d = seen_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      seen_q    <= '0;
      fc1_q     <= 1'b0;
      fc2_q     <= 1'b0;
      crc_err_q <= 1'b0;
      partner_q <= '0;
    end else begin
      crc_err_q <= chk_valid_q && !chk_ok_q;
      if (chk_valid_q && chk_ok_q) begin
        seen_q <= seen_d;
        if (&seen_d) begin
          fc1_q <= 1'b1;
        end
        case (rx_type)
          INITFC1_P:   partner_q.posted     <= rx_credit;
          INITFC1_NP:  partner_q.non_posted <= rx_credit;
          INITFC1_CPL: partner_q.completion <= rx_credit;
          INITFC2_P, INITFC2_NP, INITFC2_CPL: begin
            // FC2 only counts after FC1 is complete
            if (fc1_q) begin
              fc2_q <= 1'b1;
            end
          end
          default: begin
            fc2_q <= fc2_q;
          end
        endcase
      end
    end
  end

  assign fc1_stored_o = fc1_q;
  assign fc2_stored_o = fc2_q;
  assign partner_o    = partner_q;
  assign crc_err_o    = crc_err_q;

endmodule

//--- logic/dllp_skid_buffer.sv
// DLLP stream skid buffer
`timescale 1ns/10ps
`include "dl_params.svh"

module dllp_skid_buffer (
  input  logic               clk_i,
  input  logic               rst_i,
  input  dl_pkg::dllp_word_t s_word_i,
  input  logic               s_valid_i,
  output logic               s_ready_o,
  output dl_pkg::dllp_word_t m_word_o,
  output logic               m_valid_o,
  input  logic               m_ready_i
);
  import dl_pkg::*;

  dllp_word_t main_q;
  dllp_word_t skid_q;
  logic       main_valid_q;
  logic       skid_valid_q;
  logic       ready_q;
  logic       ready_d;

  // stay ready unless the skid entry would be filled and held
  assign ready_d = m_ready_i || (!skid_valid_q && (!main_valid_q || !s_valid_i));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_q      <= 1'b0;
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      ready_q <= ready_d;
      if (ready_q) begin
        if (m_ready_i || !main_valid_q) begin
          main_valid_q <= s_valid_i;
        end else begin
          skid_valid_q <= s_valid_i;
        end
      end else if (m_ready_i) begin
        main_valid_q <= skid_valid_q;
        skid_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_q) begin
      if (m_ready_i || !main_valid_q) begin
        main_q <= s_word_i;
      end else begin
        skid_q <= s_word_i;
      end
    end else if (m_ready_i) begin
      // drain the skid entry
      main_q <= skid_q;
    end
  end

  assign s_ready_o = ready_q;
  assign m_word_o  = main_q;
  assign m_valid_o = main_valid_q;

endmodule

//--- logic/fc_init_seq.sv
// FC init sequencer
`timescale 1ns/10ps
`include "dl_params.svh"

module fc_init_seq (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               start_i,
  input  logic               fc1_stored_i,
  input  logic               fc2_stored_i,
  input  logic               ready_i,
  input  logic [15:0]        crc_word_i,
  output logic [31:0]        body_o,
  output dl_pkg::dllp_word_t word_o,
  output logic               valid_o,
  output logic               init_ack_o,
  output logic               link_fc_done_o
);
  import dl_pkg::*;

  fc_seq_state_e state_q;
  fc_seq_state_e state_d;
  logic [3:0]    cnt_q;
  logic [3:0]    cnt_d;
  logic [15:0]   crc_q;
  logic          send_body;
  logic          send_crc;
  logic          gap_done;
  dllp_type_e    body_type;
  logic [7:0]    body_hdr;

  // linear step through body and crc states
  function automatic fc_seq_state_e step(input fc_seq_state_e s);
    case (s)
      ST_IDLE:        step = ST_FC1_P_CRC;
      ST_FC1_P:       step = ST_FC1_P_CRC;
      ST_FC1_P_CRC:   step = ST_FC1_NP;
      ST_FC1_NP:      step = ST_FC1_NP_CRC;
      ST_FC1_NP_CRC:  step = ST_FC1_CPL;
      ST_FC1_CPL:     step = ST_FC1_CPL_CRC;
      ST_FC1_CPL_CRC: step = ST_FC1_CHECK;
      ST_FC2_P:       step = ST_FC2_P_CRC;
      ST_FC2_P_CRC:   step = ST_FC2_NP;
      ST_FC2_NP:      step = ST_FC2_NP_CRC;
      ST_FC2_NP_CRC:  step = ST_FC2_CPL;
      ST_FC2_CPL:     step = ST_FC2_CPL_CRC;
      ST_FC2_CPL_CRC: step = ST_FC2_CHECK;
      default:        step = s;
    endcase
  endfunction

  // body for the DLLP this state sends
  always_comb begin
    case (state_q)
      ST_FC1_NP:  body_type = INITFC1_NP;
      ST_FC1_CPL: body_type = INITFC1_CPL;
      ST_FC2_P:   body_type = INITFC2_P;
      ST_FC2_NP:  body_type = INITFC2_NP;
      ST_FC2_CPL: body_type = INITFC2_CPL;
      default:    body_type = INITFC1_P;
    endcase
    body_hdr = (body_type == INITFC2_CPL) ? 8'd0 : 8'(`DL_HDR_MIN_CREDITS);
  end

  assign body_o   = {body_type, 2'b00, body_hdr, 2'b00, 12'(`DL_PD_MIN_CREDITS)};
  assign gap_done = (cnt_q == 4'(`DL_FC_WAIT_CYCLES));

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    send_body  = 1'b0;
    send_crc   = 1'b0;
    init_ack_o = 1'b0;
    // nothing moves while the buffer is full
    if (ready_i) begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            send_body  = 1'b1;
            init_ack_o = 1'b1;
            state_d    = step(state_q);
          end
        end
        ST_FC1_P, ST_FC1_NP, ST_FC1_CPL, ST_FC2_P, ST_FC2_NP, ST_FC2_CPL: begin
          if (gap_done) begin
            send_body = 1'b1;
            state_d   = step(state_q);
          end else begin
            cnt_d = cnt_q + 4'd1;
          end
        end
        ST_FC1_P_CRC, ST_FC1_NP_CRC, ST_FC1_CPL_CRC,
        ST_FC2_P_CRC, ST_FC2_NP_CRC, ST_FC2_CPL_CRC: begin
          send_crc = 1'b1;
          cnt_d    = '0;
          state_d  = step(state_q);
        end
        ST_FC1_CHECK: begin
          if (fc1_stored_i) begin
            cnt_d   = '0;
            state_d = ST_FC2_P;
          end else if (cnt_q == 4'(`DL_FC_CHECK_CYCLES - 1)) begin
            // partner silent, repeat FC1
            cnt_d   = '0;
            state_d = ST_FC1_P;
          end else begin
            cnt_d = cnt_q + 4'd1;
          end
        end
        ST_FC2_CHECK: begin
          if (fc2_stored_i) begin
            cnt_d   = '0;
            state_d = ST_DONE;
          end else if (cnt_q == 4'(`DL_FC_CHECK_CYCLES - 1)) begin
            cnt_d   = '0;
            state_d = ST_FC2_P;
          end else begin
            cnt_d = cnt_q + 4'd1;
          end
        end
        default: begin
          state_d = state_q;
        end
      endcase
    end
  end

  always_comb begin
    word_o      = '0;
    word_o.user = 3'd1;
    if (send_body) begin
      word_o.data = body_o;
      word_o.keep = 4'hF;
      word_o.last = 1'b0;
    end else if (send_crc) begin
      word_o.data = {16'h0000, crc_q};
      word_o.keep = 4'h3;
      word_o.last = 1'b1;
    end
  end

  assign valid_o        = send_body | send_crc;
  assign link_fc_done_o = (state_q == ST_DONE);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // crc of the body just sent
  always_ff @(posedge clk_i) begin
    if (send_body) begin
      crc_q <= crc_word_i;
    end
  end

endmodule

//--- sim.f
+incdir+logic
+incdir+test
logic/dl_pkg.sv
logic/dllp_crc16.sv
logic/fc_init_seq.sv
logic/dllp_skid_buffer.sv
logic/dllp_fc_receiver.sv
logic/dl_fc_init_top.sv
test/tb_dl_fc_init.sv

//--- test/tb_dl_fc_tasks.svh
// FC init testbench helpers
`ifndef TB_DL_FC_TASKS_SVH
`define TB_DL_FC_TASKS_SVH

// poly 100B, seed all ones, body msb first
function automatic logic [15:0] ref_crc(input logic [31:0] body);
  logic [15:0] r;
  logic [15:0] inv;
  logic [15:0] wire_crc;
  logic        fb;
  r = 16'hFFFF;
  for (int b = 31; b >= 0; b--) begin
    fb = r[15] ^ body[b];
    r  = r << 1;
    if (fb) begin
      r = r ^ 16'h100B;
    end
  end
  inv = ~r;
  // each byte goes out lsb first
  for (int k = 0; k < 16; k++) begin
    wire_crc[k] = inv[(k & 8) | (7 - (k & 7))];
  end
  return wire_crc;
endfunction

function automatic logic [31:0] ref_body(input dllp_type_e t, input fc_credit_t c);
  return {t, 2'b00, c.hdr, 2'b00, c.data};
endfunction

function automatic dllp_word_t body_word(input logic [31:0] body);
  dllp_word_t w;
  w.data = body;
  w.keep = 4'hF;
  w.last = 1'b0;
  w.user = 3'd1;
  return w;
endfunction

function automatic dllp_word_t crc_word(input logic [31:0] body);
  dllp_word_t w;
  w.data = {16'h0000, ref_crc(body)};
  w.keep = 4'h3;
  w.last = 1'b1;
  w.user = 3'd1;
  return w;
endfunction

// minimum credits, Cpl FC2 carries no header credits
task automatic expect_dllp(input dllp_type_e t);
  fc_credit_t  c;
  logic [31:0] b;
  c.hdr  = (t == INITFC2_CPL) ? 8'd0 : 8'(`DL_HDR_MIN_CREDITS);
  c.data = 12'(`DL_PD_MIN_CREDITS);
  b      = ref_body(t, c);
  exp_q.push_back(body_word(b));
  exp_q.push_back(crc_word(b));
endtask

task automatic check_word(input string name, input dllp_word_t got, input dllp_word_t exp);
  if (got !== exp) begin
    fail_run($sformatf("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp));
  end
endtask

task automatic check_credit(input string name, input fc_credit_t got, input fc_credit_t exp);
  if (got !== exp) begin
    fail_run($sformatf("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    fail_run($sformatf("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp));
  end
endtask

// partner DLLP, body then CRC word, valid left high
task automatic send_dllp(input dllp_type_e t, input fc_credit_t c, input logic corrupt);
  logic [31:0] b;
  dllp_word_t  w;
  b = ref_body(t, c);
  @(negedge clk_i);
  rx_valid_i = 1'b1;
  rx_word_i  = body_word(b);
  @(negedge clk_i);
  w = crc_word(b);
  if (corrupt) begin
    w.data[3:0] = w.data[3:0] ^ 4'h5;
  end
  rx_word_i = w;
endtask

task automatic release_rx();
  @(negedge clk_i);
  rx_valid_i = 1'b0;
  rx_word_i  = '0;
endtask

task automatic wait_words(input int n, input int budget);
  int cycles;
  cycles = 0;
  while (tx_q.size() < n) begin
    @(negedge clk_i);
    cycles++;
    if (cycles > budget) begin
      fail_run($sformatf("only %0d of %0d transmit words arrived in time", tx_q.size(), n));
    end
  end
endtask

task automatic compare_tx(input int n);
  for (int i = 0; i < n; i++) begin
    check_word($sformatf("tx_word_o[%0d]", i), tx_q[i], exp_q[i]);
  end
endtask

`endif

//--- test/tb_dl_fc_init.sv
// FC init testbench
`timescale 1ns/10ps
`include "dl_params.svh"

module tb_dl_fc_init;
  import dl_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  // cycle budgets per test
  localparam int FC1_BUDGET   = 400;
  localparam int FC2_BUDGET   = 400;
  localparam int CRC_BUDGET   = 100;
  localparam int RAND_BUDGET  = 1500;
  localparam int RUN_CYCLES   = 2 * RESET_CYCLES + FC1_BUDGET + FC2_BUDGET + CRC_BUDGET
                                + RAND_BUDGET + 500;

  localparam fc_credit_t P_CRED   = '{hdr: 8'h20, data: 12'h080};
  localparam fc_credit_t NP_CRED  = '{hdr: 8'h18, data: 12'h0C0};
  localparam fc_credit_t CPL_CRED = '{hdr: 8'h04, data: 12'h010};
  localparam fc_credit_t BAD_CRED = '{hdr: 8'h7F, data: 12'h7FF};

  logic        clk_i;
  logic        rst_i;
  logic        start_i;
  logic        tx_ready_i;
  logic        rx_valid_i;
  dllp_word_t  rx_word_i;
  dllp_word_t  tx_word_o;
  logic        tx_valid_o;
  logic        init_ack_o;
  logic        link_fc_done_o;
  logic        crc_err_o;
  fc_partner_t partner_o;
  dllp_word_t  tx_q[$];
  dllp_word_t  exp_q[$];
  dllp_word_t  held_word;
  logic        stalled;
  logic        random_ready;
  integer      seed;

  dl_fc_init_top uut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .start_i        (start_i),
    .tx_word_o      (tx_word_o),
    .tx_valid_o     (tx_valid_o),
    .tx_ready_i     (tx_ready_i),
    .rx_word_i      (rx_word_i),
    .rx_valid_i     (rx_valid_i),
    .init_ack_o     (init_ack_o),
    .link_fc_done_o (link_fc_done_o),
    .partner_o      (partner_o),
    .crc_err_o      (crc_err_o)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  `include "tb_dl_fc_tasks.svh"

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    fail_run("watchdog expired before the tests finished");
  end

  // link back-pressure
  always @(negedge clk_i) begin
    if (random_ready) begin
      tx_ready_i = 1'($random(seed) & 1);
    end
  end

  // collect transfers and hold check on a stalled word
  always @(posedge clk_i) begin
    if (stalled && !rst_i) begin
      check_bit("tx_valid_o", tx_valid_o, 1'b1);
      check_word("tx_word_o", tx_word_o, held_word);
    end
    if (tx_valid_o && tx_ready_i) begin
      tx_q.push_back(tx_word_o);
    end
    stalled   = tx_valid_o && !tx_ready_i;
    held_word = tx_word_o;
  end

  task automatic apply_reset();
    @(negedge clk_i);
    rst_i      = 1'b1;
    start_i    = 1'b0;
    rx_valid_i = 1'b0;
    rx_word_i  = '0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_i = 1'b0;
  endtask

  task automatic start_seq();
    int   cycles;
    logic acked;
    cycles = 0;
    acked  = 1'b0;
    @(negedge clk_i);
    start_i = 1'b1;
    while (!acked) begin
      @(posedge clk_i);
      acked = init_ack_o;
      cycles++;
      if (!acked && cycles > RESET_CYCLES) begin
        fail_run("init_ack_o never answered start_i");
      end
    end
    @(negedge clk_i);
    check_bit("init_ack_o", init_ack_o, 1'b0);
    start_i = 1'b0;
  endtask

  task automatic wait_done(input int budget);
    int cycles;
    cycles = 0;
    while (!link_fc_done_o) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > budget) begin
        fail_run("link_fc_done_o did not rise after the partner's InitFC2 DLLP");
      end
    end
  endtask

  task automatic check_partner();
    check_credit("partner_o.posted", partner_o.posted, P_CRED);
    check_credit("partner_o.non_posted", partner_o.non_posted, NP_CRED);
    check_credit("partner_o.completion", partner_o.completion, CPL_CRED);
  endtask

  task automatic test_reset_state();
    check_bit("tx_valid_o", tx_valid_o, 1'b0);
    check_bit("init_ack_o", init_ack_o, 1'b0);
    check_bit("link_fc_done_o", link_fc_done_o, 1'b0);
    check_bit("crc_err_o", crc_err_o, 1'b0);
    check_credit("partner_o.posted", partner_o.posted, '0);
    check_credit("partner_o.non_posted", partner_o.non_posted, '0);
    check_credit("partner_o.completion", partner_o.completion, '0);
  endtask

  task automatic test_fc1_words();
    start_seq();
    expect_dllp(INITFC1_P);
    expect_dllp(INITFC1_NP);
    expect_dllp(INITFC1_CPL);
    wait_words(6, FC1_BUDGET);
    compare_tx(6);
  endtask

  task automatic test_fc_handshake();
    // silent partner makes FC1 start over
    expect_dllp(INITFC1_P);
    wait_words(8, FC1_BUDGET);
    compare_tx(8);
    send_dllp(INITFC1_P, P_CRED, 1'b0);
    send_dllp(INITFC1_NP, NP_CRED, 1'b0);
    send_dllp(INITFC1_CPL, CPL_CRED, 1'b0);
    release_rx();
    @(negedge clk_i);
    check_partner();
    expect_dllp(INITFC1_NP);
    expect_dllp(INITFC1_CPL);
    expect_dllp(INITFC2_P);
    expect_dllp(INITFC2_NP);
    expect_dllp(INITFC2_CPL);
    wait_words(18, FC1_BUDGET);
    check_bit("link_fc_done_o", link_fc_done_o, 1'b0);
    send_dllp(INITFC2_P, P_CRED, 1'b0);
    release_rx();
    wait_done(FC2_BUDGET);
    compare_tx(18);
  endtask

  task automatic test_crc_error();
    int cycles;
    cycles = 0;
    send_dllp(INITFC1_NP, BAD_CRED, 1'b1);
    release_rx();
    while (!crc_err_o) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > CRC_BUDGET) begin
        fail_run("crc_err_o did not pulse for a corrupted CRC word");
      end
    end
    @(negedge clk_i);
    check_bit("crc_err_o", crc_err_o, 1'b0);
    check_partner();
  endtask

  task automatic test_random_ready();
    apply_reset();
    tx_q.delete();
    exp_q.delete();
    // partner flags set before the sequence starts
    send_dllp(INITFC1_P, P_CRED, 1'b0);
    send_dllp(INITFC1_NP, NP_CRED, 1'b0);
    send_dllp(INITFC1_CPL, CPL_CRED, 1'b0);
    send_dllp(INITFC2_CPL, CPL_CRED, 1'b0);
    release_rx();
    @(posedge clk_i);
    random_ready = 1'b1;
    start_seq();
    expect_dllp(INITFC1_P);
    expect_dllp(INITFC1_NP);
    expect_dllp(INITFC1_CPL);
    expect_dllp(INITFC2_P);
    expect_dllp(INITFC2_NP);
    expect_dllp(INITFC2_CPL);
    wait_done(RAND_BUDGET);
    wait_words(12, RAND_BUDGET);
    random_ready = 1'b0;
    tx_ready_i   = 1'b1;
    repeat (20) @(negedge clk_i);
    compare_tx(12);
    if (tx_q.size() != 12) begin
      fail_run($sformatf("%0d words were sent where 12 were expected", tx_q.size()));
    end
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    start_i      = 1'b0;
    tx_ready_i   = 1'b1;
    rx_valid_i   = 1'b0;
    rx_word_i    = '0;
    random_ready = 1'b0;
    stalled      = 1'b0;
    held_word    = '0;
    seed         = 32'he519_108c;
    apply_reset();
    test_reset_state();
    test_fc1_words();
    test_fc_handshake();
    test_crc_error();
    test_random_ready();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
